// ==== sim.f ====
source/rvPkg.sv
source/fetchUnit.sv
source/controller.sv
source/immGen.sv
source/registerFile.sv
source/alu.sv
source/memAccess.sv
source/cpuTop.sv
testbench/cpuTop_asserts.sv
testbench/cpuTb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  rvPkg::aluOp op,
	input  rvPkg::word  a,
	input  rvPkg::word  b,
	output rvPkg::word  result,
	output logic        zero
);
	logic [4:0] shamt;

	assign shamt = b[4:0];
	assign zero  = (result == '0); // beq taken when a - b is zero

	always_comb begin
		case (op)
			rvPkg::aluAdd:   result = a + b;
			rvPkg::aluSub:   result = a - b;
			rvPkg::aluAnd:   result = a & b;
			rvPkg::aluOr:    result = a | b;
			rvPkg::aluXor:   result = a ^ b;
			rvPkg::aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
			rvPkg::aluSltu:  result = {31'b0, a < b};
			rvPkg::aluSll:   result = a << shamt;
			rvPkg::aluSrl:   result = a >> shamt;
			rvPkg::aluSra:   result = $signed(a) >>> shamt;
			rvPkg::aluPassB: result = b;
			default:         result = '0;
		endcase
	end

endmodule

// ==== source/controller.sv ====
`timescale 1ns/1ps

module controller (
	input  rvPkg::word        inst,
	output rvPkg::ctrlSignals ctrl,
	output logic              invalid,
	output logic              ebreak
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign ebreak = (inst == rvPkg::instEbreak);

	always_comb begin
		ctrl      = '0;
		ctrl.alu  = rvPkg::aluAdd;
		ctrl.wb   = rvPkg::wbAlu;
		ctrl.size = rvPkg::sizeWord;
		ctrl.jump = rvPkg::pcSeq;
		invalid   = 1'b0;
		case (opcode)
			rvPkg::opLui: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				ctrl.alu       = rvPkg::aluPassB;
			end
			rvPkg::opAuipc: begin
				ctrl.regWrite = 1'b1;
				ctrl.wb       = rvPkg::wbPcBranch;
			end
			rvPkg::opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.wb       = rvPkg::wbPcPlus;
				ctrl.jump     = rvPkg::pcBranch;
			end
			rvPkg::opJalr: begin
				invalid        = (funct3 != 3'b000);
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1; // target is rs1 + imm
				ctrl.wb        = rvPkg::wbPcPlus;
				ctrl.jump      = invalid ? rvPkg::pcSeq : rvPkg::pcJalr;
			end
			rvPkg::opBranch: begin
				invalid     = (funct3 != 3'b000); // beq only
				ctrl.branch = !invalid;
				ctrl.alu    = rvPkg::aluSub;
			end
			rvPkg::opLoad: begin
				ctrl.regWrite   = 1'b1;
				ctrl.aluSrcImm  = 1'b1;
				ctrl.memRead    = 1'b1;
				ctrl.wb         = rvPkg::wbLoad;
				ctrl.loadSigned = !funct3[2];
				case (funct3[1:0])
					2'b00:   ctrl.size = rvPkg::sizeByte;
					2'b01:   ctrl.size = rvPkg::sizeHalf;
					default: ctrl.size = rvPkg::sizeWord;
				endcase
				invalid = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
			end
			rvPkg::opStore: begin
				ctrl.memWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				case (funct3)
					3'b000:  ctrl.size = rvPkg::sizeByte;
					3'b001:  ctrl.size = rvPkg::sizeHalf;
					3'b010:  ctrl.size = rvPkg::sizeWord;
					default: invalid = 1'b1;
				endcase
			end
			rvPkg::opImm: begin
				ctrl.regWrite  = 1'b1;
				ctrl.aluSrcImm = 1'b1;
				case (funct3)
					3'b000:  ctrl.alu = rvPkg::aluAdd;
					3'b010:  ctrl.alu = rvPkg::aluSlt;
					3'b011:  ctrl.alu = rvPkg::aluSltu;
					3'b100:  ctrl.alu = rvPkg::aluXor;
					3'b110:  ctrl.alu = rvPkg::aluOr;
					3'b111:  ctrl.alu = rvPkg::aluAnd;
					default: invalid = 1'b1; // slli, srli, srai not kept
				endcase
			end
			rvPkg::opReg: begin
				ctrl.regWrite = 1'b1;
				case (funct3)
					3'b000:  ctrl.alu = funct7[5] ? rvPkg::aluSub : rvPkg::aluAdd;
					3'b001:  ctrl.alu = rvPkg::aluSll;
					3'b010:  ctrl.alu = rvPkg::aluSlt;
					3'b011:  ctrl.alu = rvPkg::aluSltu;
					3'b100:  ctrl.alu = rvPkg::aluXor;
					3'b101:  ctrl.alu = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
					3'b110:  ctrl.alu = rvPkg::aluOr;
					default: ctrl.alu = rvPkg::aluAnd;
				endcase
				// funct7 bit 5 is only legal for sub and sra
				invalid = !((funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
			end
			default: invalid = !ebreak;
		endcase
		if (invalid) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
			ctrl.memRead  = 1'b0;
		end
	end

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
	parameter rvPkg::word resetVector = 32'h8000_0000
) (
	input  logic         clk,
	input  logic         rst,
	input  rvPkg::word   inst,
	input  rvPkg::word   readData,
	output rvPkg::word   instAddr,
	output rvPkg::memReq dataReq,
	output logic         invalid,
	output logic         ebreak
);
	rvPkg::ctrlSignals ctrl;
	rvPkg::word        pc;
	rvPkg::word        pcPlus;
	rvPkg::word        pcBranch;
	rvPkg::word        imm;
	rvPkg::word        rs1Data;
	rvPkg::word        rs2Data;
	rvPkg::word        srcB;
	rvPkg::word        aluResult;
	rvPkg::word        loadValue;
	rvPkg::word        wbData;
	logic              zero;

	assign instAddr = pc;
	assign srcB     = ctrl.aluSrcImm ? imm : rs2Data;

	always_comb begin
		case (ctrl.wb)
			rvPkg::wbLoad:     wbData = loadValue;
			rvPkg::wbPcPlus:   wbData = pcPlus;    // link address
			rvPkg::wbPcBranch: wbData = pcBranch;  // auipc
			default:           wbData = aluResult;
		endcase
	end

	fetchUnit #(.resetVector(resetVector)) fetch (
		.clk(clk), .rst(rst), .ctrl(ctrl), .zero(zero), .imm(imm),
		.jalrTarget(aluResult), .pc(pc), .pcPlus(pcPlus), .pcBranch(pcBranch)
	);

	controller decode (.inst(inst), .ctrl(ctrl), .invalid(invalid), .ebreak(ebreak));

	immGen immediate (.inst(inst), .imm(imm));

	registerFile regs (
		.clk(clk), .rst(rst), .regWrite(ctrl.regWrite),
		.rs1(inst[19:15]), .rs2(inst[24:20]), .rd(inst[11:7]),
		.wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data)
	);

	alu exec (.op(ctrl.alu), .a(rs1Data), .b(srcB), .result(aluResult), .zero(zero));

	memAccess lsu (
		.rst(rst), .ctrl(ctrl), .addr(aluResult), .storeData(rs2Data),
		.readData(readData), .dataReq(dataReq), .loadValue(loadValue)
	);

endmodule

// ==== source/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit #(
	parameter rvPkg::word resetVector = 32'h8000_0000
) (
	input  logic              clk,
	input  logic              rst,
	input  rvPkg::ctrlSignals ctrl,
	input  logic              zero,
	input  rvPkg::word        imm,
	input  rvPkg::word        jalrTarget,
	output rvPkg::word        pc,
	output rvPkg::word        pcPlus,
	output rvPkg::word        pcBranch
);
	rvPkg::pcSel sel;
	rvPkg::word  nextPc;

	assign pcPlus   = pc + 32'd4;
	assign pcBranch = pc + imm; // jal, beq and auipc target

	always_comb begin
		if (ctrl.jump == rvPkg::pcJalr)
			sel = rvPkg::pcJalr;
		else if (ctrl.jump == rvPkg::pcBranch || (ctrl.branch && zero))
			sel = rvPkg::pcBranch;
		else
			sel = rvPkg::pcSeq;
		case (sel)
			rvPkg::pcJalr:   nextPc = {jalrTarget[31:1], 1'b0};
			rvPkg::pcBranch: nextPc = pcBranch;
			default:         nextPc = pcPlus;
		endcase
		// nothing is mapped below the reset vector
		if (nextPc < resetVector)
			nextPc = resetVector;
	end

	always_ff @(posedge clk) begin
		if (!rst)
			pc <= resetVector;
		else
			pc <= nextPc;
	end

endmodule

// ==== source/immGen.sv ====
`timescale 1ns/1ps

module immGen (
	input  rvPkg::word inst,
	output rvPkg::word imm
);
	logic [6:0] opcode;

	assign opcode = inst[6:0];

	always_comb begin
		case (opcode)
			rvPkg::opImm, rvPkg::opLoad, rvPkg::opJalr:
				imm = {{20{inst[31]}}, inst[31:20]};
			rvPkg::opStore:
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			rvPkg::opBranch: // bit 0 is always zero
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			rvPkg::opLui, rvPkg::opAuipc:
				imm = {inst[31:12], 12'b0};
			rvPkg::opJal:
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

// ==== source/memAccess.sv ====
`timescale 1ns/1ps

module memAccess (
	input  logic              rst,
	input  rvPkg::ctrlSignals ctrl,
	input  rvPkg::word        addr,
	input  rvPkg::word        storeData,
	input  rvPkg::word        readData,
	output rvPkg::memReq      dataReq,
	output rvPkg::word        loadValue
);
	rvPkg::word byteLane;
	rvPkg::word halfLane;

	assign dataReq.addr  = addr; // memory rounds down to the word
	assign dataReq.read  = ctrl.memRead && rst;
	assign dataReq.write = ctrl.memWrite && rst;

	// lane shifted down to bit 0
	assign byteLane = readData >> {addr[1:0], 3'b000};
	assign halfLane = readData >> {addr[1], 4'b0000};

	always_comb begin
		case (ctrl.size)
			rvPkg::sizeByte: begin
				dataReq.wmask = 4'b0001 << addr[1:0];
				dataReq.wdata = {4{storeData[7:0]}};
				loadValue     = {{24{ctrl.loadSigned & byteLane[7]}}, byteLane[7:0]};
			end
			rvPkg::sizeHalf: begin
				dataReq.wmask = 4'b0011 << {addr[1], 1'b0};
				dataReq.wdata = {2{storeData[15:0]}};
				loadValue     = {{16{ctrl.loadSigned & halfLane[15]}}, halfLane[15:0]};
			end
			default: begin
				dataReq.wmask = 4'b1111;
				dataReq.wdata = storeData;
				loadValue     = readData;
			end
		endcase
	end

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input  logic           clk,
	input  logic           rst,
	input  logic           regWrite,
	input  rvPkg::regIndex rs1,
	input  rvPkg::regIndex rs2,
	input  rvPkg::regIndex rd,
	input  rvPkg::word     wdata,
	output rvPkg::word     rdata1,
	output rvPkg::word     rdata2
);
	rvPkg::word regs [32];

	// x0 is cleared at reset and never written
	assign rdata1 = regs[rs1];
	assign rdata2 = regs[rs2];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (regWrite && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

// ==== source/rvPkg.sv ====
package rvPkg;

	typedef logic [31:0] word;
	typedef logic [4:0]  regIndex;

	// alu operation codes
	typedef logic [3:0] aluOp;
	localparam aluOp aluAdd   = 4'd0;
	localparam aluOp aluSub   = 4'd1;
	localparam aluOp aluAnd   = 4'd2;
	localparam aluOp aluOr    = 4'd3;
	localparam aluOp aluXor   = 4'd4;
	localparam aluOp aluSlt   = 4'd5;
	localparam aluOp aluSltu  = 4'd6;
	localparam aluOp aluSll   = 4'd7;
	localparam aluOp aluSrl   = 4'd8;
	localparam aluOp aluSra   = 4'd9;
	localparam aluOp aluPassB = 4'd10; // lui

	// write-back source
	typedef logic [1:0] wbSel;
	localparam wbSel wbAlu      = 2'd0;
	localparam wbSel wbLoad     = 2'd1;
	localparam wbSel wbPcPlus   = 2'd2;
	localparam wbSel wbPcBranch = 2'd3; // auipc

	typedef logic [1:0] pcSel;
	localparam pcSel pcSeq    = 2'd0;
	localparam pcSel pcBranch = 2'd1;
	localparam pcSel pcJalr   = 2'd2;

	// one-hot width of a data access
	typedef logic [2:0] accessSize;
	localparam accessSize sizeByte = 3'b001;
	localparam accessSize sizeHalf = 3'b010;
	localparam accessSize sizeWord = 3'b100;

	typedef struct packed {
		logic      regWrite;
		logic      aluSrcImm;
		aluOp      alu;
		wbSel      wb;
		logic      memRead;
		logic      memWrite;
		accessSize size;
		logic      loadSigned;
		logic      branch;
		pcSel      jump;   // pcBranch for jal, pcJalr for jalr
	} ctrlSignals;

	typedef struct packed {
		word        addr;
		word        wdata;
		logic [3:0] wmask;
		logic       read;
		logic       write;
	} memReq;

	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam word        instEbreak = 32'h0010_0073;

endpackage

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	typedef struct packed {
		rvPkg::word   instAddr;
		rvPkg::memReq req;
		logic         invalid;
		logic         ebreak;
	} expectedOut;

	logic         clk;
	logic         rst;
	rvPkg::word   inst;
	rvPkg::word   readData;
	rvPkg::word   instAddr;
	rvPkg::memReq dataReq;
	logic         invalid;
	logic         ebreak;

	rvPkg::word imem [128];
	rvPkg::word dmem [256];
	rvPkg::word modelMem [256];
	rvPkg::word modelRegs [32];
	rvPkg::word modelPc = 32'h8000_0000;
	integer     seed = 32'he813_33b6;
	int         progLen = 0;
	int         cycleLimit = 1000;
	int         cycles = 0;

	cpuTop #(.resetVector(32'h8000_0000)) dut0 (
		.clk(clk), .rst(rst), .inst(inst), .readData(readData),
		.instAddr(instAddr), .dataReq(dataReq), .invalid(invalid), .ebreak(ebreak)
	);

	// both memories answer within the cycle
	assign inst     = $isunknown(instAddr) ? '0 : imem[instAddr[8:2]];
	assign readData = $isunknown(dataReq.addr) ? '0 : dmem[dataReq.addr[9:2]];

	always @(posedge clk) begin
		if (dataReq.write) begin
			for (int i = 0; i < 4; i++)
				if (dataReq.wmask[i])
					dmem[dataReq.addr[9:2]][8*i +: 8] <= dataReq.wdata[8*i +: 8];
		end
	end

	function automatic rvPkg::word rType(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rvPkg::opReg};
	endfunction

	function automatic rvPkg::word iType(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
			logic [4:0] rs1, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvPkg::word sType(logic [11:0] imm, logic [2:0] f3, logic [4:0] rs1,
			logic [4:0] rs2);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::opStore};
	endfunction

	// beq only
	function automatic rvPkg::word bType(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rvPkg::opBranch};
	endfunction

	function automatic rvPkg::word uType(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rvPkg::word jType(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
	endfunction

	function automatic void emit(rvPkg::word w);
		imem[progLen] = w;
		progLen++;
	endfunction

	function automatic void buildProgram();
		rvPkg::word r;
		logic       alt;
		emit(uType(20'h80002, 5'd1, rvPkg::opLui)); // x1 = data base
		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			emit(uType(r[31:12], 5'd2, rvPkg::opLui));
			emit(iType(r[11:0], 3'b000, 5'd2, 5'd2, rvPkg::opImm));
			r = $random(seed);
			alt = r[0] && (k == 0 || k == 5); // sub and sra
			emit(uType(r[31:12], 5'd3, rvPkg::opLui));
			// x2 as rs2 so shifts get a random amount
			emit(rType({1'b0, alt, 5'b0}, k[2:0], 5'd4, 5'd3, 5'd2));
			emit(sType(4 * k, 3'b010, 5'd1, 5'd4));
			r = $random(seed);
			// k 1 and 5 would be immediate shifts
			emit(iType(r[31:20], (k == 1) ? 3'b000 : (k == 5) ? 3'b100 : k[2:0], 5'd5, 5'd2,
				rvPkg::opImm));
			emit(sType(64 + 4 * k, 3'b010, 5'd1, 5'd5));
		end
		for (int off = 0; off < 4; off++)
			emit(sType(128 + off, 3'b000, 5'd1, 5'd2));
		emit(sType(136, 3'b001, 5'd1, 5'd2));
		emit(sType(138, 3'b001, 5'd1, 5'd3));
		emit(sType(140, 3'b010, 5'd1, 5'd3));
		// loads at every legal offset with each result stored right after
		for (int off = 0; off < 4; off++) begin
			for (int f = 0; f < 6; f++) begin
				if (f != 3 && !(f[1:0] == 2'b01 && off[0]) && !(f == 2 && off != 0)) begin
					emit(iType(200 + off, f[2:0], 5'd6, 5'd1, rvPkg::opLoad));
					emit(sType(288, 3'b010, 5'd1, 5'd6));
				end
			end
		end
		emit(bType(13'd8, 5'd0, 5'd0)); // taken
		emit(iType(12'd1, 3'b000, 5'd4, 5'd0, rvPkg::opImm));
		emit(bType(13'd8, 5'd1, 5'd0)); // not taken
		emit(jType(21'd8, 5'd7));
		emit(iType(12'd1, 3'b000, 5'd4, 5'd0, rvPkg::opImm));
		emit(sType(292, 3'b010, 5'd1, 5'd7));
		emit(uType(20'd0, 5'd8, rvPkg::opAuipc));
		emit(iType(12'd16, 3'b000, 5'd9, 5'd8, rvPkg::opJalr)); // lands two words on
		emit(iType(12'd1, 3'b000, 5'd4, 5'd0, rvPkg::opImm));
		emit(iType(12'd1, 3'b000, 5'd4, 5'd0, rvPkg::opImm));
		emit(sType(296, 3'b010, 5'd1, 5'd9));
		emit(sType(300, 3'b010, 5'd1, 5'd8));
		emit(iType(12'd1, 3'b001, 5'd4, 5'd2, rvPkg::opImm)); // slli, unsupported
		emit(32'hffff_ffff);
		emit(sType(304, 3'b010, 5'd1, 5'd4)); // x4 untouched by the above
		emit(rvPkg::instEbreak);
	endfunction

	function automatic rvPkg::word aluRef(logic [2:0] f3, logic alt, rvPkg::word a,
			rvPkg::word b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return rvPkg::word'($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes one instruction on the model state
	function automatic expectedOut stepModel();
		expectedOut e;
		rvPkg::word instr;
		rvPkg::word a;
		rvPkg::word b;
		rvPkg::word res;
		rvPkg::word addr;
		rvPkg::word lane;
		rvPkg::word nextPc;
		rvPkg::word iImm;
		rvPkg::word sImm;
		rvPkg::word bImm;
		rvPkg::word jImm;
		logic       wr;
		instr  = imem[modelPc[8:2]];
		a      = modelRegs[instr[19:15]];
		b      = modelRegs[instr[24:20]];
		iImm   = {{20{instr[31]}}, instr[31:20]};
		sImm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		bImm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		jImm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		e          = '0;
		e.instAddr = modelPc;
		e.ebreak   = (instr == 32'h0010_0073);
		nextPc     = modelPc + 32'd4;
		wr         = 1'b1;
		res        = '0;
		case (instr[6:0])
			rvPkg::opLui:   res = {instr[31:12], 12'b0};
			rvPkg::opAuipc: res = modelPc + {instr[31:12], 12'b0};
			rvPkg::opJal: begin
				res    = nextPc;
				nextPc = modelPc + jImm;
			end
			rvPkg::opJalr: begin
				res    = nextPc;
				nextPc = (a + iImm) & ~32'd1;
			end
			rvPkg::opBranch: begin
				wr = 1'b0;
				if (a == b)
					nextPc = modelPc + bImm;
			end
			rvPkg::opLoad: begin
				addr       = a + iImm;
				e.req.addr = addr;
				e.req.read = 1'b1;
				lane       = modelMem[addr[9:2]] >> (8 * addr[1:0]);
				case (instr[14:12])
					3'b000:  res = {{24{lane[7]}}, lane[7:0]};
					3'b001:  res = {{16{lane[15]}}, lane[15:0]};
					3'b100:  res = {24'b0, lane[7:0]};
					3'b101:  res = {16'b0, lane[15:0]};
					default: res = lane;
				endcase
			end
			rvPkg::opStore: begin
				wr          = 1'b0;
				addr        = a + sImm;
				e.req.addr  = addr;
				e.req.write = 1'b1;
				e.req.wmask = 4'b1111;
				e.req.wdata = b;
				if (instr[14:12] == 3'b000) begin
					e.req.wmask = 4'b0001 << addr[1:0];
					e.req.wdata = {4{b[7:0]}};
				end else if (instr[14:12] == 3'b001) begin
					e.req.wmask = 4'b0011 << addr[1:0];
					e.req.wdata = {2{b[15:0]}};
				end
				for (int i = 0; i < 4; i++)
					if (e.req.wmask[i])
						modelMem[addr[9:2]][8*i +: 8] = e.req.wdata[8*i +: 8];
			end
			rvPkg::opImm: begin
				e.invalid = (instr[13:12] == 2'b01); // shift immediates
				res       = aluRef(instr[14:12], 1'b0, a, iImm);
			end
			rvPkg::opReg: res = aluRef(instr[14:12], instr[30], a, b);
			default: begin
				wr        = 1'b0;
				e.invalid = !e.ebreak;
			end
		endcase
		if (wr && !e.invalid && instr[11:7] != 5'd0)
			modelRegs[instr[11:7]] = res;
		if (nextPc < 32'h8000_0000)
			nextPc = 32'h8000_0000;
		modelPc = nextPc;
		return e;
	endfunction

	task automatic compareWord(string name, rvPkg::word got, rvPkg::word exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic compareFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("** Error: %s = %h, expected %h", name, got, exp);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic compareReq(rvPkg::memReq got, rvPkg::memReq exp);
		compareFlag("dataReq.read", got.read, exp.read);
		compareFlag("dataReq.write", got.write, exp.write);
		if (exp.read || exp.write)
			compareWord("dataReq.addr", got.addr, exp.addr);
		if (exp.write) begin
			compareWord("dataReq.wdata", got.wdata, exp.wdata);
			compareWord("dataReq.wmask", {28'b0, got.wmask}, {28'b0, exp.wmask});
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		rst = 1'b0;
		for (int i = 0; i < 128; i++)
			imem[i] = rvPkg::instEbreak;
		for (int i = 0; i < 256; i++) begin
			dmem[i]     = (i * 4 + 1) * 32'h9e37_79b9; // from the byte address
			modelMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		buildProgram();
		cycleLimit = progLen * 2 + 20;
		repeat (3) @(posedge clk);
		#2 rst = 1'b1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout: ebreak not reached within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin : compareProcess
		expectedOut exp;
		logic       done;
		done = 1'b0;
		@(negedge clk);
		compareWord("instAddr", instAddr, 32'h8000_0000); // held during reset
		wait (rst);
		while (!done) begin
			@(negedge clk);
			exp = stepModel();
			compareWord("instAddr", instAddr, exp.instAddr);
			compareReq(dataReq, exp.req);
			compareFlag("invalid", invalid, exp.invalid);
			compareFlag("ebreak", ebreak, exp.ebreak);
			done = exp.ebreak;
		end
		if (dut0.checks.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("TB FAILED");
			$fatal(1, "bound assertions failed %0d times", dut0.checks.failCount);
		end
	end

endmodule

// ==== testbench/cpuTop_asserts.sv ====
`timescale 1ns/1ps

module cpuTopAsserts #(
	parameter rvPkg::word resetVector = 32'h8000_0000
) (
	input logic         clk,
	input logic         rst,
	input rvPkg::word   pc,
	input rvPkg::memReq dataReq
);
	int failCount = 0; // read by the testbench when the run ends

	noAccessInReset: assert property (@(posedge clk) !rst |-> !dataReq.write && !dataReq.read)
		else begin
			failCount = failCount + 1;
			$error("memory request while in reset");
		end

	// pc stays inside the program space
	pcInRange: assert property (@(posedge clk) disable iff (!rst)
		pc[1:0] == 2'b00 && pc >= resetVector)
		else begin
			failCount = failCount + 1;
			$error("pc %h misaligned or below the reset vector", pc);
		end

	maskOnWrite: assert property (@(posedge clk) dataReq.write |-> dataReq.wmask != 4'b0000)
		else begin
			failCount = failCount + 1;
			$error("store with an empty byte mask");
		end

endmodule

bind cpuTop cpuTopAsserts #(.resetVector(resetVector)) checks (
	.clk(clk), .rst(rst), .pc(pc), .dataReq(dataReq)
);
